/* hdl/lcdPkg.sv */
package lcdPkg;

   // --------------------------------------------------
   // bus and payload widths
   // --------------------------------------------------
   typedef logic [3:0]  nibbleT;          // one transfer on the 4-bit bus
   typedef logic [7:0]  byteT;            // command or character code
   typedef logic [19:0] waitCountT;       // cycles, 750000 fits
   typedef logic [4:0]  stepIndexT;       // script position

   // init wait, 4 init nibbles, 4 config bytes, 10 characters
   localparam stepIndexT scriptLength = 5'd19;

   // --------------------------------------------------
   // script step encodings
   // --------------------------------------------------
   typedef enum logic [1:0]
   {
      stepWait,                           // no bus cycle, wait only
      stepNibble,                         // high nibble only, init phase
      stepByte                            // high then low nibble
   } stepKindT;

   typedef enum logic [2:0]
   {
      waitPowerOn,                        // 15 ms after power up
      waitLong,                           // 4.1 ms after first 0x3
      waitShort,                          // 100 us after second 0x3
      waitCommand,                        // 40 us, most commands
      waitClear                           // 1.64 ms after clear display
   } waitClassT;

   // --------------------------------------------------
   // state machines
   // --------------------------------------------------
   typedef enum logic [2:0]
   {
      writerIdle,                         // waiting for stepStart
      writerSetup,                        // data and RS ahead of enable
      writerPulse,                        // enable high
      writerHold,                         // data held after enable falls
      writerGap,                          // between high and low nibble
      writerWait                          // post step delay
   } writerStateT;

   typedef enum logic [1:0]
   {
      seqIdle,                            // one cycle after reset
      seqIssue,                           // launch current step
      seqWaiting,                         // step in flight
      seqFinished                         // phrase written, hold done
   } sequencerStateT;

   // --------------------------------------------------
   // default timing, clock cycles at 50 MHz
   // --------------------------------------------------
   localparam waitCountT defaultPowerOnWait = 20'd750000;
   localparam waitCountT defaultLongWait    = 20'd205000;
   localparam waitCountT defaultShortWait   = 20'd5000;
   localparam waitCountT defaultCommandWait = 20'd2000;
   localparam waitCountT defaultClearWait   = 20'd82000;
   localparam waitCountT defaultNibbleGap   = 20'd50;   // 1 us between nibbles
   localparam waitCountT defaultEnableWidth = 20'd12;   // 240 ns enable pulse

endpackage

/* hdl/lcdScript.sv */
module lcdScript
(
   input  lcdPkg::stepIndexT stepIndex,
   output lcdPkg::stepKindT  stepKind,
   output lcdPkg::byteT      stepByte,
   output logic              stepRegisterSelect,
   output lcdPkg::waitClassT stepWait
);
   import lcdPkg::*;

   // the ports stepWait and stepByte hide the enum literals of the
   // same name, those are spelled with the package prefix here

   always_comb
   begin
      // out of range lands on a harmless short wait
      stepKind           = lcdPkg::stepWait;
      stepByte           = 8'h00;
      stepRegisterSelect = 1'b0;            // commands by default
      stepWait           = waitCommand;
      case (stepIndex)
         // --------------------------------------------------
         // power on init, high nibble only
         // --------------------------------------------------
         5'd0:  stepWait = waitPowerOn;     // let Vcc settle
         5'd1:
         begin
            stepKind = stepNibble;
            stepByte = 8'h30;               // first 0x3
            stepWait = waitLong;
         end
         5'd2:
         begin
            stepKind = stepNibble;
            stepByte = 8'h30;
            stepWait = waitShort;
         end
         5'd3:
         begin
            stepKind = stepNibble;
            stepByte = 8'h30;
         end
         5'd4:
         begin
            stepKind = stepNibble;
            stepByte = 8'h20;               // switch to 4-bit mode
         end
         // --------------------------------------------------
         // configuration, full bytes
         // --------------------------------------------------
         5'd5:
         begin
            stepKind = lcdPkg::stepByte;
            stepByte = 8'h28;               // function set, 2 lines
         end
         5'd6:
         begin
            stepKind = lcdPkg::stepByte;
            stepByte = 8'h06;               // entry mode, increment
         end
         5'd7:
         begin
            stepKind = lcdPkg::stepByte;
            stepByte = 8'h0C;               // display on, no cursor
         end
         5'd8:
         begin
            stepKind = lcdPkg::stepByte;
            stepByte = 8'h01;               // clear display
            stepWait = waitClear;           // clear is slow
         end
         // --------------------------------------------------
         // phrase
         // --------------------------------------------------
         5'd9:  stepByte = "H";
         5'd10: stepByte = "o";
         5'd11: stepByte = "l";
         5'd12: stepByte = "a";
         5'd13: stepByte = " ";
         5'd14: stepByte = "M";
         5'd15: stepByte = "u";
         5'd16: stepByte = "n";
         5'd17: stepByte = "d";
         5'd18: stepByte = "o";
         default: ;
      endcase
      // every character is a data write
      if (stepIndex >= 5'd9 && stepIndex < scriptLength)
      begin
         stepKind           = lcdPkg::stepByte;
         stepRegisterSelect = 1'b1;
      end
   end

endmodule

/* hdl/lcdSequencer.sv */
module lcdSequencer
(
   input  logic              Clock,
   input  logic              reset,
   input  logic              stepDone,     // writer finished step and wait
   output lcdPkg::stepIndexT stepIndex,
   output logic              stepStart,    // one cycle launch pulse
   output logic              phraseDone
);
   import lcdPkg::*;

   sequencerStateT state;
   logic           lastStep;

   assign lastStep   = (stepIndex == scriptLength - 1'b1);
   assign phraseDone = (state == seqFinished);   // level until reset

   // --------------------------------------------------
   // step walker, one step in flight
   // --------------------------------------------------
   always_ff @(posedge Clock)
   begin
      if (reset)
      begin
         state     <= seqIdle;
         stepIndex <= '0;
         stepStart <= 1'b0;
      end
      else
      begin
         stepStart <= 1'b0;                // pulse only
         case (state)
            seqIdle:
            begin
               stepIndex <= '0;            // restart from power on wait
               state     <= seqIssue;
            end
            seqIssue:
            begin
               stepStart <= 1'b1;          // script fields valid now
               state     <= seqWaiting;
            end
            seqWaiting:
            begin
               if (stepDone)
               begin
                  if (lastStep)
                  begin
                     state <= seqFinished; // last char and its wait done
                  end
                  else
                  begin
                     stepIndex <= stepIndex + 1'b1;
                     state     <= seqIssue;
                  end
               end
            end
            seqFinished:
            begin
               state <= seqFinished;       // phrase written once, idle
            end
            default:
            begin
               state <= seqIdle;
            end
         endcase
      end
   end

endmodule

/* hdl/lcdNibbleWriter.sv */
module lcdNibbleWriter
#(
   parameter lcdPkg::waitCountT PowerOnWait = lcdPkg::defaultPowerOnWait,
   parameter lcdPkg::waitCountT LongWait    = lcdPkg::defaultLongWait,
   parameter lcdPkg::waitCountT ShortWait   = lcdPkg::defaultShortWait,
   parameter lcdPkg::waitCountT CommandWait = lcdPkg::defaultCommandWait,
   parameter lcdPkg::waitCountT ClearWait   = lcdPkg::defaultClearWait,
   parameter lcdPkg::waitCountT NibbleGap   = lcdPkg::defaultNibbleGap,
   parameter lcdPkg::waitCountT EnableWidth = lcdPkg::defaultEnableWidth
)
(
   input  logic              Clock,
   input  logic              reset,
   input  logic              stepStart,
   input  lcdPkg::stepKindT  stepKind,
   input  lcdPkg::byteT      stepByte,
   input  logic              stepRegisterSelect,
   input  lcdPkg::waitClassT stepWait,
   output logic              stepDone,
   output lcdPkg::nibbleT    lcdData,
   output logic              lcdRegisterSelect,
   output logic              lcdEnable
);
   import lcdPkg::*;

   // counter loads are length minus one, state moves when count hits 0
   localparam waitCountT SetupLoad = waitCountT'(1);     // 2 cycles before E
   localparam waitCountT PulseLoad = EnableWidth - 1'b1;
   localparam waitCountT GapLoad   = NibbleGap - 1'b1;

   writerStateT state;
   waitCountT   count;
   logic        countDone;
   logic        lowPending;                // low nibble still to send
   nibbleT      lowNibble;                 // captured step payload
   logic        heldSelect;
   waitClassT   heldWait;

   assign countDone = (count == '0);

   function automatic waitCountT waitLoad(input waitClassT waitClass);
      case (waitClass)
         waitPowerOn: return PowerOnWait - 1'b1;
         waitLong:    return LongWait - 1'b1;
         waitShort:   return ShortWait - 1'b1;
         waitClear:   return ClearWait - 1'b1;
         default:     return CommandWait - 1'b1;
      endcase
   endfunction

   // payload capture, only taken when a step starts
   always_ff @(posedge Clock)
   begin
      if (state == writerIdle && stepStart)
      begin
         lowNibble  <= stepByte[3:0];
         heldSelect <= stepRegisterSelect;
         heldWait   <= stepWait;
      end
   end

   // --------------------------------------------------
   // nibble timing FSM
   // --------------------------------------------------
   always_ff @(posedge Clock)
   begin
      if (reset)
      begin
         state             <= writerIdle;
         count             <= '0;
         lowPending        <= 1'b0;
         stepDone          <= 1'b0;
         lcdData           <= '0;
         lcdRegisterSelect <= 1'b0;
         lcdEnable         <= 1'b0;
      end
      else
      begin
         stepDone <= 1'b0;                 // pulse only
         if (!countDone)
         begin
            count <= count - 1'b1;         // loads below take priority
         end
         case (state)
            writerIdle:
            begin
               if (stepStart && stepKind == lcdPkg::stepWait)
               begin
                  count <= waitLoad(stepWait);   // no bus cycle
                  state <= writerWait;
               end
               else if (stepStart)
               begin
                  lcdData           <= stepByte[7:4];   // high nibble first
                  lcdRegisterSelect <= stepRegisterSelect;
                  lowPending        <= (stepKind == lcdPkg::stepByte);
                  count             <= SetupLoad;
                  state             <= writerSetup;
               end
            end
            writerSetup:
            begin
               if (countDone)
               begin
                  lcdEnable <= 1'b1;
                  count     <= PulseLoad;
                  state     <= writerPulse;
               end
            end
            writerPulse:
            begin
               if (countDone)
               begin
                  lcdEnable <= 1'b0;       // LCD latches on falling E
                  state     <= writerHold;
               end
            end
            writerHold:
            begin
               lcdData           <= '0;    // bus back to idle
               lcdRegisterSelect <= 1'b0;
               if (lowPending)
               begin
                  lowPending <= 1'b0;
                  count      <= GapLoad;
                  state      <= writerGap;
               end
               else
               begin
                  count <= waitLoad(heldWait);
                  state <= writerWait;
               end
            end
            writerGap:
            begin
               if (countDone)
               begin
                  lcdData           <= lowNibble;
                  lcdRegisterSelect <= heldSelect;
                  count             <= SetupLoad;
                  state             <= writerSetup;
               end
            end
            writerWait:
            begin
               if (countDone)
               begin
                  stepDone <= 1'b1;        // step fully complete
                  state    <= writerIdle;
               end
            end
            default:
            begin
               state <= writerIdle;
            end
         endcase
      end
   end

endmodule

/* hdl/lcdControl.sv */
module lcdControl
#(
   parameter lcdPkg::waitCountT PowerOnWait = lcdPkg::defaultPowerOnWait,
   parameter lcdPkg::waitCountT LongWait    = lcdPkg::defaultLongWait,
   parameter lcdPkg::waitCountT ShortWait   = lcdPkg::defaultShortWait,
   parameter lcdPkg::waitCountT CommandWait = lcdPkg::defaultCommandWait,
   parameter lcdPkg::waitCountT ClearWait   = lcdPkg::defaultClearWait,
   parameter lcdPkg::waitCountT NibbleGap   = lcdPkg::defaultNibbleGap,
   parameter lcdPkg::waitCountT EnableWidth = lcdPkg::defaultEnableWidth
)
(
   input  logic           Clock,
   input  logic           reset,
   output lcdPkg::nibbleT lcdData,         // LCD DB7..DB4
   output logic           lcdRegisterSelect, // 0 command, 1 data
   output logic           lcdEnable,
   output logic           phraseDone
);
   import lcdPkg::*;

   // --------------------------------------------------
   // sequencer to script to writer
   // --------------------------------------------------
   stepIndexT stepIndex;
   stepKindT  stepKind;
   byteT      stepByte;
   logic      stepRegisterSelect;
   waitClassT stepWait;
   logic      stepStart;
   logic      stepDone;

   lcdSequencer sequencer
   (
      .Clock      (Clock),
      .reset      (reset),
      .stepDone   (stepDone),
      .stepIndex  (stepIndex),
      .stepStart  (stepStart),
      .phraseDone (phraseDone)
   );

   lcdScript script
   (
      .stepIndex          (stepIndex),
      .stepKind           (stepKind),
      .stepByte           (stepByte),
      .stepRegisterSelect (stepRegisterSelect),
      .stepWait           (stepWait)
   );

   lcdNibbleWriter
   #(
      .PowerOnWait (PowerOnWait),
      .LongWait    (LongWait),
      .ShortWait   (ShortWait),
      .CommandWait (CommandWait),
      .ClearWait   (ClearWait),
      .NibbleGap   (NibbleGap),
      .EnableWidth (EnableWidth)
   )
   writer
   (
      .Clock              (Clock),
      .reset              (reset),
      .stepStart          (stepStart),
      .stepKind           (stepKind),
      .stepByte           (stepByte),
      .stepRegisterSelect (stepRegisterSelect),
      .stepWait           (stepWait),
      .stepDone           (stepDone),
      .lcdData            (lcdData),
      .lcdRegisterSelect  (lcdRegisterSelect),
      .lcdEnable          (lcdEnable)
   );

endmodule

/* bench/lcdControl_asserts.sv */
module lcdControlAsserts
#(
   parameter lcdPkg::waitCountT EnableWidth = lcdPkg::defaultEnableWidth
)
(
   input logic           Clock,
   input logic           reset,
   input lcdPkg::nibbleT lcdData,
   input logic           lcdRegisterSelect,
   input logic           lcdEnable,
   input logic           phraseDone
);

   // --------------------------------------------------
   // LCD bus protocol
   // --------------------------------------------------
   // data and RS steady through the pulse and at the falling edge
   busStable: assert property (@(posedge Clock) disable iff (reset)
      $past(lcdEnable) |-> $stable(lcdData) && $stable(lcdRegisterSelect))
      else $error("lcdData or lcdRegisterSelect changed under lcdEnable");

   enableWidthExact: assert property (@(posedge Clock) disable iff (reset)
      $rose(lcdEnable) |-> lcdEnable [*EnableWidth] ##1 !lcdEnable)
      else $error("lcdEnable pulse width differs from EnableWidth");

   quietAfterDone: assert property (@(posedge Clock) disable iff (reset)
      phraseDone |-> !lcdEnable)
      else $error("lcdEnable high after phraseDone");

   // outputs settle one edge into reset
   lowInReset: assert property (@(posedge Clock)
      reset && $past(reset) |-> !lcdEnable && !lcdRegisterSelect && lcdData == '0
                                && !phraseDone)
      else $error("outputs not low during reset");

endmodule

bind lcdControl lcdControlAsserts #(.EnableWidth(EnableWidth)) asserts
(
   .Clock             (Clock),
   .reset             (reset),
   .lcdData           (lcdData),
   .lcdRegisterSelect (lcdRegisterSelect),
   .lcdEnable         (lcdEnable),
   .phraseDone        (phraseDone)
);

/* bench/lcdControlTb.sv */
module lcdControlTb;
   import lcdPkg::*;

   // short waits so a full run stays in the low thousands of cycles
   localparam int powerOnWait = 300;
   localparam int longWait    = 120;
   localparam int shortWait   = 60;
   localparam int commandWait = 40;
   localparam int clearWait   = 90;
   localparam int nibbleGap   = 8;
   localparam int enableWidth = 12;
   localparam int resetCycles = 16;
   localparam int idleCheck   = 200;           // quiet cycles after phraseDone

   // one run is the waits plus 32 pulses with setup and hold plus step overhead
   localparam int runCycles = powerOnWait + longWait + shortWait + 15 * commandWait
                            + clearWait + 32 * (enableWidth + 4) + 16 * nibbleGap + 19 * 4;
   // two full runs plus the partial run of the reset test and a margin
   localparam int cycleLimit = 2 * (runCycles + 2 * resetCycles + idleCheck) + runCycles + 500;

   logic   Clock;
   logic   reset;
   nibbleT lcdData;
   logic   lcdRegisterSelect;
   logic   lcdEnable;
   logic   phraseDone;

   int errorCount = 0;
   int checkCount = 0;
   int cycleCount = 0;

   // expected and observed nibble lists
   int expectData[$];
   int expectSelect[$];
   int expectGap[$];                           // idle cycles before the pulse
   bit exactGap[$];                            // low nibbles have a fixed gap
   int seenData[$];
   int seenSelect[$];
   int seenGap[$];
   int seenWidth[$];

   lcdControl
   #(
      .PowerOnWait (powerOnWait),
      .LongWait    (longWait),
      .ShortWait   (shortWait),
      .CommandWait (commandWait),
      .ClearWait   (clearWait),
      .NibbleGap   (nibbleGap),
      .EnableWidth (enableWidth)
   )
   DUT
   (
      .Clock             (Clock),
      .reset             (reset),
      .lcdData           (lcdData),
      .lcdRegisterSelect (lcdRegisterSelect),
      .lcdEnable         (lcdEnable),
      .phraseDone        (phraseDone)
   );

   always #10 Clock = ~Clock;

   always @(posedge Clock)
   begin
      cycleCount++;
      if (cycleCount >= cycleLimit)
      begin
         $display("timeout: phraseDone never rose");
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // bus monitor sampled mid cycle
   // --------------------------------------------------
   int enablePrev = 0;
   int highCycles = 0;
   int lowCycles  = 0;
   int gapBefore  = 0;

   always @(negedge Clock)
   begin
      if (reset)
      begin
         enablePrev = 0;                       // cut pulses are not recorded
         highCycles = 0;
         lowCycles  = 0;
      end
      else
      begin
         if (lcdEnable)
         begin
            if (!enablePrev)
               gapBefore = lowCycles;
            highCycles++;
         end
         else
         begin
            if (enablePrev)
            begin
               seenData.push_back(lcdData);    // still held one cycle
               seenSelect.push_back(lcdRegisterSelect);
               seenGap.push_back(gapBefore);
               seenWidth.push_back(highCycles);
               highCycles = 0;
               lowCycles  = 0;
            end
            lowCycles++;
         end
         enablePrev = lcdEnable;
      end
   end

   task automatic checkValue(input int actual, input int expected, input string what);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("error at time %0t: %s (expected %0d, got %0d)", $time, what, expected,
                  actual);
      end
   endtask

   // high nibble waits out the previous step and the low nibble gap is hold plus gap plus setup
   task automatic addByte(input int value, input int select, input int waitBefore);
      expectData.push_back(value >> 4);
      expectSelect.push_back(select);
      expectGap.push_back(waitBefore);
      exactGap.push_back(1'b0);
      expectData.push_back(value & 4'hF);
      expectSelect.push_back(select);
      expectGap.push_back(1 + nibbleGap + 2);
      exactGap.push_back(1'b1);
   endtask

   task automatic buildExpected();
      int    initNibble[4] = '{3, 3, 3, 2};
      int    initGap[4]    = '{powerOnWait, longWait, shortWait, commandWait};
      string phrase        = "Hola Mundo";
      int    i;
      for (i = 0; i < 4; i++)
      begin
         expectData.push_back(initNibble[i]);
         expectSelect.push_back(0);
         expectGap.push_back(initGap[i]);
         exactGap.push_back(1'b0);
      end
      addByte(8'h28, 0, commandWait);          // function set
      addByte(8'h06, 0, commandWait);          // entry mode
      addByte(8'h0C, 0, commandWait);          // display on
      addByte(8'h01, 0, commandWait);          // clear
      for (i = 0; i < phrase.len(); i++)
         addByte(phrase[i], 1, (i == 0) ? clearWait : commandWait);
   endtask

   task automatic applyReset();
      @(posedge Clock);
      #2 reset = 1'b1;
      repeat (resetCycles - 1) @(posedge Clock);
      @(negedge Clock);
      checkValue(lcdEnable, 0, "lcdEnable in reset");
      checkValue(lcdRegisterSelect, 0, "lcdRegisterSelect in reset");
      checkValue(lcdData, 0, "lcdData in reset");
      checkValue(phraseDone, 0, "phraseDone in reset");
      @(posedge Clock);
      #2 reset = 1'b0;
      seenData.delete();
      seenSelect.delete();
      seenGap.delete();
      seenWidth.delete();
   endtask

   task automatic checkRun(input string runName);
      int i;
      int seenAtDone;
      while (!phraseDone)
         @(negedge Clock);
      checkValue(seenData.size(), expectData.size(), {runName, " nibble count"});
      for (i = 0; i < expectData.size() && i < seenData.size(); i++)
      begin
         checkValue(seenData[i], expectData[i], $sformatf("%s nibble %0d data", runName, i));
         checkValue(seenSelect[i], expectSelect[i], $sformatf("%s nibble %0d RS", runName, i));
         checkValue(seenWidth[i], enableWidth, $sformatf("%s pulse %0d width", runName, i));
         if (exactGap[i])
            checkValue(seenGap[i], expectGap[i], $sformatf("%s gap before %0d", runName, i));
         else
            checkValue(seenGap[i] >= expectGap[i], 1,
                       $sformatf("%s gap before %0d too short", runName, i));
      end
      seenAtDone = seenData.size();
      repeat (idleCheck) @(negedge Clock);
      checkValue(seenData.size(), seenAtDone, {runName, " pulses after phraseDone"});
      checkValue(phraseDone, 1, {runName, " phraseDone held"});
   endtask

   // --------------------------------------------------
   // directed tests
   // --------------------------------------------------
   task automatic testFullSequence();
      applyReset();
      checkRun("first run");
   endtask

   task automatic testResetMidConfig();
      applyReset();
      while (seenData.size() < 7)              // init, 0x28 and high nibble of 0x06 sent
         @(negedge Clock);
      applyReset();                            // lands between the nibbles of 0x06
      checkRun("restart");
   endtask

   initial
   begin
      Clock = 1'b0;
      reset = 1'b1;
      buildExpected();
      testFullSequence();
      testResetMidConfig();
      $display("%0d errors in %0d checks", errorCount, checkCount);
      if (errorCount == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* src.f */
hdl/lcdPkg.sv
hdl/lcdScript.sv
hdl/lcdSequencer.sv
hdl/lcdNibbleWriter.sv
hdl/lcdControl.sv
bench/lcdControl_asserts.sv
bench/lcdControlTb.sv

/* Bender.yml */
package:
  name: lcdcontrol

sources:
  - hdl/lcdPkg.sv
  - hdl/lcdScript.sv
  - hdl/lcdSequencer.sv
  - hdl/lcdNibbleWriter.sv
  - hdl/lcdControl.sv
  - target: simulation
    files:
      - bench/lcdControl_asserts.sv
      - bench/lcdControlTb.sv
